//--- bench/pat_tb_tests.svh
`ifndef PAT_TB_TESTS_SVH
`define PAT_TB_TESTS_SVH

// ============================================================
// instruction words and program control
// ============================================================

// i8 word is {fieldp, cond, field_op, op8, imm}
function automatic logic [`PAT_I_WIDTH-1:0] long_form(input logic [3:0] op,
	input logic [7:0] imm, input logic [1:0] cond = 2'd0, input logic fop = 1'b0,
	input logic [`PAT_FIELDP_WIDTH-1:0] fp = '0);
	return {fp, cond, fop, op, imm};
endfunction

// i3 sits behind the F escape with its op in imm[7:4]
function automatic logic [`PAT_I_WIDTH-1:0] short_form(input logic [3:0] op3,
	input logic [3:0] low, input logic fop = 1'b0, input logic [`PAT_FIELDP_WIDTH-1:0] fp = '0);
	return {fp, 2'd0, fop, 4'hF, op3, low};
endfunction

// i0 behind both escapes
function automatic logic [`PAT_I_WIDTH-1:0] bare_form(input logic [3:0] op0,
	input logic fop = 1'b0, input logic [`PAT_FIELDP_WIDTH-1:0] fp = '0);
	return {fp, 2'd0, fop, 4'hF, 4'hF, op0};
endfunction

task automatic emit(input logic [`PAT_I_WIDTH-1:0] word);
	rom[prog_len] = word;
	prog_len++;
endtask

// holds the DUT in reset while the rom is rewritten
task automatic begin_program();
	int i;
	@(posedge clk);
	#DRIVE_DELAY;
	reset = 1'b1;
	for (i = 0; i < ROM_DEPTH; i++)
		rom[i] = pat_isa_pkg::NOP_INSTR;   // padding
	prog_len = 0;
endtask

task automatic release_reset();
	repeat (3) @(posedge clk);
	#DRIVE_DELAY;
	reset = 1'b0;
endtask

// the last word commits two edges after its fetch and its field write lands one edge later
task automatic wait_end();
	int cycles;
	cycles = 0;
	@(negedge clk);
	while (int'(o_pc) != prog_len + 3 && cycles < PROGRAM_CYCLES)
	begin
		@(negedge clk);
		cycles++;
	end
	if (int'(o_pc) != prog_len + 3)
	begin
		errors++;
		$display("program of %0d words never reached its end address", prog_len);
	end
endtask

task automatic run_program();
	release_reset();
	wait_end();
endtask

task automatic fill_fields();
	int i;
	for (i = 0; i < FIELD_DEPTH; i++)
	begin
		field_low[i] <= 8'(i * 37 + 5);     // odd steps keep every entry distinct
		field_high[i] <= 8'(i * 53 + 200);
	end
endtask

task automatic check_log(input string name, input logic [7:0] expected [$]);
	int i;
	check({name, " output count"}, expected.size(), out_log.size());
	for (i = 0; i < expected.size() && i < out_log.size(); i++)
		check({name, " output value"}, expected[i], out_log[i]);
endtask

// ============================================================
// accumulator ops
// ============================================================

function automatic logic [7:0] alu_model(input int op, input logic [7:0] a, input logic [7:0] b);
	logic [2:0] s;
	s = b[2:0];
	case (op)
		0: return a + b;
		1: return a - b;
		2: return a | b;
		3: return a & b;
		4: return ~a;
		5: return a << s;
		6: return (a << s) | 8'((9'd1 << s) - 9'd1);   // ones shifted in
		7: return a >> s;
		default: return 8'($signed(a) >>> s);
	endcase
endfunction

function automatic logic [`PAT_I_WIDTH-1:0] alu_instr(input int op, input logic [7:0] b);
	case (op)
		0: return long_form(pat_isa_pkg::OP8_ADD, b);
		1: return long_form(pat_isa_pkg::OP8_SUB, b);
		2: return long_form(pat_isa_pkg::OP8_OR, b);
		3: return long_form(pat_isa_pkg::OP8_AND, b);
		4: return bare_form(pat_isa_pkg::OP0_NOT);
		5: return short_form(pat_isa_pkg::OP3_SHL, {1'b0, b[2:0]});
		6: return short_form(pat_isa_pkg::OP3_SHLO, {1'b0, b[2:0]});
		7: return short_form(pat_isa_pkg::OP3_SHR, {1'b0, b[2:0]});
		default: return short_form(pat_isa_pkg::OP3_ASR, {1'b0, b[2:0]});
	endcase
endfunction

task automatic reset_and_out();
	logic [7:0] v;
	v = 8'($urandom()) | 8'h01;
	begin_program();
	emit(long_form(pat_isa_pkg::OP8_LDI, v));
	emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
	release_reset();
	check("o_outputs after reset", 0, o_outputs);
	check("o_jump after reset", 0, o_jump);
	check("o_field.we_low after reset", 0, o_field.we_low);
	check("o_field.we_high after reset", 0, o_field.we_high);
	wait_end();
	check("o_outputs after ldi, out", v, o_outputs);
endtask

task automatic alu_sweep();
	string      names [9];
	logic [7:0] a, b;
	int         op;
	names = '{"add", "sub", "or", "and", "not", "shl", "shlo", "shr", "asr"};
	for (op = 0; op < 9; op++)
	begin
		a = 8'($urandom());
		b = 8'($urandom());
		begin_program();
		emit(long_form(pat_isa_pkg::OP8_LDI, a));
		emit(alu_instr(op, b));
		emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
		run_program();
		check({"o_outputs for ", names[op]}, alu_model(op, a, b), o_outputs);
	end
endtask

// ============================================================
// memory, field and branch programs
// ============================================================

task automatic memory_ops();
	string      names [5];
	logic [3:0] ops [5];
	logic [7:0] a, b, expected;
	logic [3:0] x;
	int         i;
	names = '{"addm", "subm", "orm", "andm", "ldm"};
	ops = '{pat_isa_pkg::OP8_ADDM, pat_isa_pkg::OP8_SUBM, pat_isa_pkg::OP8_ORM,
		pat_isa_pkg::OP8_ANDM, pat_isa_pkg::OP8_LDM};
	for (i = 0; i < 5; i++)
	begin
		a = 8'($urandom());
		b = 8'($urandom());
		x = 4'($urandom());
		case (i)
			0: expected = b + a;
			1: expected = b - a;
			2: expected = b | a;
			3: expected = b & a;
			default: expected = a;   // ldm replaces b
		endcase
		begin_program();
		emit(long_form(pat_isa_pkg::OP8_LDI, a));
		emit(long_form(pat_isa_pkg::OP8_STM, {4'h0, x}));
		emit(pat_isa_pkg::NOP_INSTR);                 // load right after store sees stale data
		emit(long_form(pat_isa_pkg::OP8_LDI, b));
		emit(long_form(ops[i], {4'h0, x}));
		emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
		run_program();
		check({"o_outputs for ", names[i]}, expected, o_outputs);
	end
endtask

task automatic field_ops();
	logic [7:0] pre, b, v, w, inp;
	logic [7:0] exp_q [$];
	pre = 8'($urandom());
	b = 8'($urandom()) | 8'h01;          // nonzero so the sum differs from the preset
	v = 8'($urandom()) | 8'h80;          // top bit keeps v apart from the preset at 7
	w = {1'b1, 7'($urandom())};          // top bit keeps w apart from inp
	inp = {1'b0, 7'($urandom())} | 8'h01;
	begin_program();
	fill_fields();
	field_high[3] <= pre;
	field_high[12] <= w;
	i_inputs = inp;
	emit(short_form(pat_isa_pkg::OP3_SETB, 4'hA));   // high side and bufp 2
	emit(pat_isa_pkg::NOP_INSTR);                       // select settles before the next read
	emit(long_form(pat_isa_pkg::OP8_ADD, b, 2'd0, 1'b1, 5'd3));
	emit(long_form(pat_isa_pkg::OP8_LDI, v));
	emit(bare_form(pat_isa_pkg::OP0_MOV, 1'b1, 5'd7));  // acc to field
	emit(bare_form(pat_isa_pkg::OP0_MOV, 1'b0, 5'd12)); // field to acc
	emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
	emit(short_form(pat_isa_pkg::OP3_IN, 4'h0));
	emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
	run_program();
	check("o_bufp after setb", 2, o_bufp);
	check("field_high[3] after field add", 8'(pre + b), field_high[3]);
	check("field_low[3] untouched", 8'(3 * 37 + 5), field_low[3]);
	check("field_high[7] after mov to field", v, field_high[7]);
	check("we_low pulses", 0, we_low_count);
	check("we_high pulses", 2, we_high_count);
	exp_q = {w, inp};
	check_log("mov from field, in", exp_q);
endtask

task automatic branch_case(input string name, input logic [7:0] first, input logic taken);
	logic [7:0] mark [5];
	logic [7:0] exp_q [$];
	mark = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h5A};
	begin_program();
	emit(long_form(pat_isa_pkg::OP8_LDI, first));
	emit(bare_form(pat_isa_pkg::OP0_TEST));
	emit(long_form(pat_isa_pkg::OP8_LDI, mark[0]));
	emit(long_form(pat_isa_pkg::OP8_BF, 8'd8, pat_isa_pkg::COND_Z));   // 3 + 8 = 11
	emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));        // 4 to 6 sit in the shadow
	emit(long_form(pat_isa_pkg::OP8_LDI, mark[1]));
	emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
	emit(long_form(pat_isa_pkg::OP8_LDI, mark[2]));      // 7 to 10 skipped when taken
	emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
	emit(long_form(pat_isa_pkg::OP8_LDI, mark[3]));
	emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
	emit(long_form(pat_isa_pkg::OP8_ADD, mark[4]));      // target adds onto the acc it inherits
	emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
	run_program();
	if (taken)
		exp_q = {8'(mark[0] + mark[4])};
	else
		exp_q = {mark[0], mark[1], mark[2], mark[3], 8'(mark[3] + mark[4])};
	check_log(name, exp_q);
	check({name, " o_jump pulses"}, taken ? 1 : 0, jump_count);
endtask

task automatic cond_n_load();
	logic [7:0] exp_q [$];
	begin_program();
	emit(long_form(pat_isa_pkg::OP8_LDI, 8'h05));
	emit(bare_form(pat_isa_pkg::OP0_TEST));                         // n clear
	emit(long_form(pat_isa_pkg::OP8_LDI, 8'h33, pat_isa_pkg::COND_N)); // dropped
	emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
	emit(long_form(pat_isa_pkg::OP8_LDI, 8'h90));
	emit(bare_form(pat_isa_pkg::OP0_TEST));                         // n set
	emit(long_form(pat_isa_pkg::OP8_LDI, 8'h44, pat_isa_pkg::COND_N));
	emit(short_form(pat_isa_pkg::OP3_OUT, 4'h0));
	run_program();
	exp_q = {8'h05, 8'h44};
	check_log("ldi on n", exp_q);
endtask

`endif

//--- bench/pat_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "pat_cfg.svh"

module pat_tb;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;          // inputs change this long after the rising edge
	localparam int N_PROGRAMS = 19;          // programs run by all tests together
	localparam int PROGRAM_CYCLES = 32;      // reset plus the longest program, with slack
	localparam int WATCHDOG_NS = (N_PROGRAMS * PROGRAM_CYCLES + 50) * CLK_PERIOD;
	localparam int ROM_DEPTH = 1 << `PAT_I_ADR_WIDTH;
	localparam int FIELD_DEPTH = 1 << `PAT_FIELDP_WIDTH;

	logic                        clk;
	logic                        reset;
	pat_isa_pkg::instr_t         i_instr;
	logic [`PAT_D_WIDTH-1:0]     i_field_low;
	logic [`PAT_D_WIDTH-1:0]     i_field_high;
	logic [`PAT_D_WIDTH-1:0]     i_inputs;
	logic [`PAT_I_ADR_WIDTH-1:0] o_pc;
	logic                        o_jump;
	logic [`PAT_BUFP_WIDTH-1:0]  o_bufp;
	pat_bus_pkg::field_port_t    o_field;
	logic [`PAT_D_WIDTH-1:0]     o_outputs;

	logic [`PAT_I_WIDTH-1:0] rom [ROM_DEPTH];          // program memory model
	logic [`PAT_D_WIDTH-1:0] field_low [FIELD_DEPTH];
	logic [`PAT_D_WIDTH-1:0] field_high [FIELD_DEPTH];
	int                      prog_len;                 // words loaded for the current program
	int                      errors;
	logic [`PAT_D_WIDTH-1:0] out_log [$];              // every new value seen on o_outputs
	logic [`PAT_D_WIDTH-1:0] last_out;
	int                      jump_count, we_low_count, we_high_count;

	pat_core uut (.clk, .reset, .i_instr, .i_field_low, .i_field_high, .i_inputs,
		.o_pc, .o_jump, .o_bufp, .o_field, .o_outputs);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ============================================================
	// external memories
	// ============================================================

	assign i_instr = rom[o_pc];                     // same-cycle fetch
	assign i_field_low = field_low[o_field.fieldp];
	assign i_field_high = field_high[o_field.fieldp];

	always @(posedge clk)
	begin
		if (o_field.we_low)
			field_low[o_field.fieldwp] <= o_field.wdata;
		if (o_field.we_high)
			field_high[o_field.fieldwp] <= o_field.wdata;
	end

	// output changes and pulses, sampled mid-cycle
	always @(negedge clk)
	begin
		if (reset)
		begin
			out_log.delete();
			last_out = '0;     // o_outputs clears in reset
			jump_count = 0;
			we_low_count = 0;
			we_high_count = 0;
		end
		else
		begin
			if (o_outputs !== last_out)
				out_log.push_back(o_outputs);
			last_out = o_outputs;
			if (o_jump)
				jump_count++;
			if (o_field.we_low)
				we_low_count++;
			if (o_field.we_high)
				we_high_count++;
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
		end
	endtask

	`include "pat_tb_tests.svh"

	// ============================================================
	// watchdog and main sequence
	// ============================================================

	initial
	begin
		#(WATCHDOG_NS);
		$display("simulation timed out after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h8b7c));
		errors = 0;
		reset = 1'b1;
		i_inputs = '0;
		prog_len = 0;
		for (int i = 0; i < ROM_DEPTH; i++)
			rom[i] = pat_isa_pkg::NOP_INSTR;
		fill_fields();                 // no X on the field read path
		reset_and_out();
		alu_sweep();
		memory_ops();
		field_ops();
		branch_case("taken bf", 8'h00, 1'b1);   // test of zero sets z
		branch_case("untaken bf", 8'h05, 1'b0);
		cond_n_load();
		$display("tests finished with %0d error(s)", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/pat_alu_lane.sv
`timescale 1ns/10ps
`default_nettype none

`include "pat_cfg.svh"

module pat_alu_lane (
	input  pat_bus_pkg::lane_in_t   i_lane,
	output logic [`PAT_D_WIDTH-1:0] o_y
);

	logic [2:0]              sh;         // shift distance from low bits of b
	logic [`PAT_D_WIDTH-1:0] ones_fill;  // vacated positions for shlo

	assign sh = i_lane.b[2:0];
	assign ones_fill = ~({`PAT_D_WIDTH{1'b1}} << sh);

	always_comb
	begin
		case (i_lane.op)
			pat_isa_pkg::ALU_PASS_B: o_y = i_lane.b;               // ldi, ldm
			pat_isa_pkg::ALU_OR:     o_y = i_lane.a | i_lane.b;
			pat_isa_pkg::ALU_AND:    o_y = i_lane.a & i_lane.b;
			pat_isa_pkg::ALU_NOT:    o_y = ~i_lane.a;
			pat_isa_pkg::ALU_ADD:    o_y = i_lane.a + i_lane.b;   // wraps at data width
			pat_isa_pkg::ALU_SUB:    o_y = i_lane.a - i_lane.b;
			pat_isa_pkg::ALU_SHL:    o_y = i_lane.a << sh;
			pat_isa_pkg::ALU_SHLO:   o_y = (i_lane.a << sh) | ones_fill;
			pat_isa_pkg::ALU_SHR:    o_y = i_lane.a >> sh;
			pat_isa_pkg::ALU_ASR:    o_y = $signed(i_lane.a) >>> sh;  // sign bit kept
			default:                 o_y = i_lane.b;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/pat_bus_pkg.sv
`default_nettype none

`include "pat_cfg.svh"

package pat_bus_pkg;

	// everything leaving the core toward the field buffers
	typedef struct packed {
		logic [`PAT_FIELDP_WIDTH-1:0] fieldp;   // read pointer, fetch stage
		logic [`PAT_FIELDP_WIDTH-1:0] fieldwp;  // write pointer, commit stage
		logic                         we_low;
		logic                         we_high;
		logic [`PAT_D_WIDTH-1:0]      wdata;
	} field_port_t;

	typedef struct packed {
		logic [`PAT_D_WIDTH-1:0] a;
		logic [`PAT_D_WIDTH-1:0] b;
		pat_isa_pkg::alu_op_e    op;
	} lane_in_t;

	typedef struct packed {
		logic                           we;
		logic [`PAT_DMEM_ADR_WIDTH-1:0] adr;
		logic [`PAT_D_WIDTH-1:0]        data;
	} dmem_wr_t;

endpackage

`default_nettype wire

//--- logic/pat_cfg.svh
`ifndef PAT_CFG_SVH
`define PAT_CFG_SVH

// ============================================================
// core sizing
// ============================================================

`define PAT_I_WIDTH         20  // one instruction word
`define PAT_I_ADR_WIDTH     10  // program address space
`define PAT_D_WIDTH         8   // accumulator, field and memory data

// data memory
`define PAT_DMEM_DEPTH      16  // words
`define PAT_DMEM_ADR_WIDTH  4   // log2 of the depth

// field port
`define PAT_FIELDP_WIDTH    5   // field read/write pointer
`define PAT_BUFP_WIDTH      3   // buffer select driven by setb

// younger instructions dropped behind a taken bf
// covers decode reg, fetch reg and the word on i_instr
`define PAT_BRANCH_SHADOW   3

`endif

//--- logic/pat_commit.sv
`timescale 1ns/10ps
`default_nettype none

`include "pat_cfg.svh"

module pat_commit (
	input  logic                          clk,
	input  logic                          reset,
	input  pat_isa_pkg::decoded_t         i_dec,
	input  logic [`PAT_D_WIDTH-1:0]       i_acc_y,      // lane 0 result
	input  logic [`PAT_D_WIDTH-1:0]       i_field_y,    // lane 1 result
	input  logic [`PAT_D_WIDTH-1:0]       i_field_val,  // registered field read
	input  logic [`PAT_D_WIDTH-1:0]       i_inputs,
	output logic [`PAT_D_WIDTH-1:0]       o_acc,
	output logic                          o_high_sel,
	output logic [`PAT_BUFP_WIDTH-1:0]    o_bufp,
	output logic                          o_field_we_low,
	output logic                          o_field_we_high,
	output logic [`PAT_FIELDP_WIDTH-1:0]  o_fieldwp,
	output logic [`PAT_D_WIDTH-1:0]       o_field_wdata,
	output pat_bus_pkg::dmem_wr_t         o_dmem_wr,
	output logic                          o_branch,
	output logic [`PAT_I_ADR_WIDTH-1:0]   o_branch_target,
	output logic [`PAT_D_WIDTH-1:0]       o_outputs
);

	localparam int SHW = $clog2(`PAT_BRANCH_SHADOW + 1);

	logic [`PAT_D_WIDTH-1:0]     acc_q, acc_d;
	logic                        z_q, n_q;          // flags, written by test only
	logic [SHW-1:0]              shadow_q;          // squash count behind a taken bf
	logic                        cond_ok;
	logic                        commit_en;
	logic [`PAT_D_WIDTH-1:0]     field_d;
	logic [`PAT_D_WIDTH-1:0]     test_val;
	logic [`PAT_I_ADR_WIDTH-1:0] target_d;

	// ============================================================
	// condition check and result select
	// ============================================================

	always_comb
	begin
		case (i_dec.cond)
			pat_isa_pkg::COND_Z: cond_ok = z_q;
			pat_isa_pkg::COND_N: cond_ok = n_q;
			default:             cond_ok = 1'b1;  // al and al2
		endcase
	end

	assign commit_en = cond_ok && (shadow_q == '0);

	assign acc_d = i_dec.src_in ? i_inputs : i_dec.is_mov ? i_field_val : i_acc_y;
	assign field_d = i_dec.is_mov ? acc_q : i_dec.src_in ? i_inputs : i_field_y;
	assign test_val = i_dec.field_op ? i_field_val : acc_q;
	// forward offset is sign extended from the byte immediate
	assign target_d = i_dec.addr +
		{{(`PAT_I_ADR_WIDTH-`PAT_D_WIDTH){i_dec.imm[`PAT_D_WIDTH-1]}}, i_dec.imm};

	// store lands on this edge so a load two slots later sees it
	assign o_dmem_wr.we = commit_en && i_dec.dest_dmem;
	assign o_dmem_wr.adr = i_dec.imm[`PAT_DMEM_ADR_WIDTH-1:0];
	assign o_dmem_wr.data = i_dec.field_op ? i_field_val : acc_q;

	// ============================================================
	// architectural state
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc_q <= '0;
			z_q <= 1'b0;
			n_q <= 1'b0;
			o_high_sel <= 1'b0;
			o_bufp <= '0;
			o_outputs <= '0;
			shadow_q <= '0;
			o_field_we_low <= 1'b0;
			o_field_we_high <= 1'b0;
			o_branch <= 1'b0;
		end
		else
		begin
			o_field_we_low <= commit_en && i_dec.dest_field && !o_high_sel;
			o_field_we_high <= commit_en && i_dec.dest_field && o_high_sel;
			o_branch <= commit_en && i_dec.is_branch;  // single cycle pulse
			if (commit_en && i_dec.is_branch)
				shadow_q <= SHW'(`PAT_BRANCH_SHADOW);
			else if (shadow_q != '0)
				shadow_q <= shadow_q - 1'b1;
			if (commit_en)
			begin
				if (i_dec.dest_acc)
					acc_q <= acc_d;
				if (i_dec.is_test)
				begin
					z_q <= (test_val == '0);
					n_q <= test_val[`PAT_D_WIDTH-1];
				end
				if (i_dec.is_out)
					o_outputs <= acc_q;
				if (i_dec.is_setb)
				begin
					o_bufp <= i_dec.imm[`PAT_BUFP_WIDTH-1:0];
					o_high_sel <= i_dec.imm[`PAT_BUFP_WIDTH];  // bit 3 picks high side
				end
			end
		end
		o_fieldwp <= i_dec.fieldp;   // write pointer rides with the instruction
		o_field_wdata <= field_d;
		o_branch_target <= target_d;
	end

	assign o_acc = acc_q;

	// one buffer side per write
	a_we_onehot: assert property (@(posedge clk) disable iff (reset)
		!(o_field_we_low && o_field_we_high));

	// no second branch can take while the first one's shadow drains
	a_branch_shadow: assert property (@(posedge clk) disable iff (reset)
		$rose(o_branch) |-> ($past(shadow_q) == '0));

endmodule

`default_nettype wire

//--- logic/pat_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "pat_cfg.svh"

module pat_core (
	input  logic                        clk,
	input  logic                        reset,
	input  pat_isa_pkg::instr_t         i_instr,
	input  logic [`PAT_D_WIDTH-1:0]     i_field_low,
	input  logic [`PAT_D_WIDTH-1:0]     i_field_high,
	input  logic [`PAT_D_WIDTH-1:0]     i_inputs,
	output logic [`PAT_I_ADR_WIDTH-1:0] o_pc,
	output logic                        o_jump,
	output logic [`PAT_BUFP_WIDTH-1:0]  o_bufp,
	output pat_bus_pkg::field_port_t    o_field,
	output logic [`PAT_D_WIDTH-1:0]     o_outputs
);

	logic [`PAT_D_WIDTH-1:0]        dmem_rdata, acc, wdata;
	logic [`PAT_DMEM_ADR_WIDTH-1:0] dmem_radr;
	logic [`PAT_FIELDP_WIDTH-1:0]   fieldp, fieldwp;
	pat_bus_pkg::lane_in_t [1:0]    dec_lanes, lane_in;
	logic [1:0][`PAT_D_WIDTH-1:0]   lane_y;       // 0: acc lane, 1: field lane
	pat_isa_pkg::decoded_t          dec;
	pat_bus_pkg::dmem_wr_t          dmem_wr;
	logic                           high_sel, we_low, we_high, branch;
	logic [`PAT_I_ADR_WIDTH-1:0]    target;

	pat_program_counter u_pc (.clk, .reset, .i_branch(branch), .i_target(target), .o_pc);

	pat_decode u_decode (.clk, .reset, .i_instr, .i_pc(o_pc), .i_dmem_rdata(dmem_rdata),
		.i_field_low, .i_field_high, .i_high_sel(high_sel), .o_fieldp(fieldp),
		.o_dmem_radr(dmem_radr), .o_lanes(dec_lanes), .o_dec(dec));

	// acc lane reads the live accumulator
	assign lane_in[0] = '{a: acc, b: dec_lanes[0].b, op: dec_lanes[0].op};
	assign lane_in[1] = dec_lanes[1];

	genvar g;
	generate
		for (g = 0; g < 2; g++)
		begin : g_lane
			pat_alu_lane u_lane (.i_lane(lane_in[g]), .o_y(lane_y[g]));
		end
	endgenerate

	pat_commit u_commit (.clk, .reset, .i_dec(dec), .i_acc_y(lane_y[0]), .i_field_y(lane_y[1]),
		.i_field_val(dec_lanes[1].a), .i_inputs, .o_acc(acc), .o_high_sel(high_sel), .o_bufp,
		.o_field_we_low(we_low), .o_field_we_high(we_high), .o_fieldwp(fieldwp),
		.o_field_wdata(wdata), .o_dmem_wr(dmem_wr), .o_branch(branch),
		.o_branch_target(target), .o_outputs);

	pat_data_mem u_dmem (.clk, .i_radr(dmem_radr), .i_wr(dmem_wr), .o_rdata(dmem_rdata));

	assign o_jump = branch;
	assign o_field = '{fieldp: fieldp, fieldwp: fieldwp, we_low: we_low, we_high: we_high,
		wdata: wdata};

endmodule

`default_nettype wire

//--- logic/pat_data_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "pat_cfg.svh"

module pat_data_mem (
	input  logic                           clk,
	input  logic [`PAT_DMEM_ADR_WIDTH-1:0] i_radr,
	input  pat_bus_pkg::dmem_wr_t          i_wr,
	output logic [`PAT_D_WIDTH-1:0]        o_rdata
);

	logic [`PAT_D_WIDTH-1:0] mem [`PAT_DMEM_DEPTH];

	assign o_rdata = mem[i_radr];  // read in the decode cycle

	always_ff @(posedge clk)
	begin
		if (i_wr.we)
			mem[i_wr.adr] <= i_wr.data;
	end

endmodule

`default_nettype wire

//--- logic/pat_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "pat_cfg.svh"

module pat_decode (
	input  logic                           clk,
	input  logic                           reset,
	input  pat_isa_pkg::instr_t            i_instr,
	input  logic [`PAT_I_ADR_WIDTH-1:0]    i_pc,          // address of i_instr
	input  logic [`PAT_D_WIDTH-1:0]        i_dmem_rdata,
	input  logic [`PAT_D_WIDTH-1:0]        i_field_low,
	input  logic [`PAT_D_WIDTH-1:0]        i_field_high,
	input  logic                           i_high_sel,
	output logic [`PAT_FIELDP_WIDTH-1:0]   o_fieldp,
	output logic [`PAT_DMEM_ADR_WIDTH-1:0] o_dmem_radr,
	output pat_bus_pkg::lane_in_t [1:0]    o_lanes,
	output pat_isa_pkg::decoded_t          o_dec
);

	pat_isa_pkg::instr_t           fetch_q;     // fetch register
	logic [`PAT_I_ADR_WIDTH-1:0]   fetch_pc_q;
	pat_isa_pkg::op3_e             op3;
	pat_isa_pkg::op0_e             op0;
	logic                          is_i8, is_i3;
	logic                          dest_reg;    // result lands in acc or field
	logic                          src_dmem;
	pat_isa_pkg::decoded_t         dec_d, dec_q;
	logic [`PAT_D_WIDTH-1:0]       b_d, b_q;    // shared lane operand b
	logic [`PAT_D_WIDTH-1:0]       fval_q;      // field value, lane 1 operand a

	// ============================================================
	// format split by escape prefix
	// ============================================================

	assign op3 = pat_isa_pkg::op3_e'(fetch_q.imm[7:4]);
	assign op0 = pat_isa_pkg::op0_e'(fetch_q.imm[3:0]);
	assign is_i8 = (fetch_q.op8 != pat_isa_pkg::OP8_ESC);
	assign is_i3 = !is_i8 && (op3 != pat_isa_pkg::OP3_ESC);  // else i0

	always_comb
	begin
		dec_d = '0;                                // nop unless matched
		dec_d.cond = fetch_q.cond;
		dec_d.field_op = fetch_q.field_op;
		dec_d.imm = fetch_q.imm;
		dec_d.addr = fetch_pc_q;
		dec_d.fieldp = fetch_q.fieldp;
		dest_reg = 1'b0;
		src_dmem = 1'b0;
		if (is_i8)
		begin
			case (fetch_q.op8)
				pat_isa_pkg::OP8_OR:   begin dec_d.alu_op = pat_isa_pkg::ALU_OR;  dest_reg = 1'b1; end
				pat_isa_pkg::OP8_AND:  begin dec_d.alu_op = pat_isa_pkg::ALU_AND; dest_reg = 1'b1; end
				pat_isa_pkg::OP8_ADD:  begin dec_d.alu_op = pat_isa_pkg::ALU_ADD; dest_reg = 1'b1; end
				pat_isa_pkg::OP8_SUB:  begin dec_d.alu_op = pat_isa_pkg::ALU_SUB; dest_reg = 1'b1; end
				pat_isa_pkg::OP8_ORM:  begin dec_d.alu_op = pat_isa_pkg::ALU_OR;  dest_reg = 1'b1; src_dmem = 1'b1; end
				pat_isa_pkg::OP8_ANDM: begin dec_d.alu_op = pat_isa_pkg::ALU_AND; dest_reg = 1'b1; src_dmem = 1'b1; end
				pat_isa_pkg::OP8_ADDM: begin dec_d.alu_op = pat_isa_pkg::ALU_ADD; dest_reg = 1'b1; src_dmem = 1'b1; end
				pat_isa_pkg::OP8_SUBM: begin dec_d.alu_op = pat_isa_pkg::ALU_SUB; dest_reg = 1'b1; src_dmem = 1'b1; end
				pat_isa_pkg::OP8_LDI:  dest_reg = 1'b1;             // pass_b of the immediate
				pat_isa_pkg::OP8_LDM:  begin dest_reg = 1'b1; src_dmem = 1'b1; end
				pat_isa_pkg::OP8_BF:   dec_d.is_branch = 1'b1;
				pat_isa_pkg::OP8_STM:  dec_d.dest_dmem = 1'b1;
				default: ;                                           // unused slots act as nop
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				pat_isa_pkg::OP3_SHL:  begin dec_d.alu_op = pat_isa_pkg::ALU_SHL;  dest_reg = 1'b1; end
				pat_isa_pkg::OP3_SHLO: begin dec_d.alu_op = pat_isa_pkg::ALU_SHLO; dest_reg = 1'b1; end
				pat_isa_pkg::OP3_SHR:  begin dec_d.alu_op = pat_isa_pkg::ALU_SHR;  dest_reg = 1'b1; end
				pat_isa_pkg::OP3_ASR:  begin dec_d.alu_op = pat_isa_pkg::ALU_ASR;  dest_reg = 1'b1; end
				pat_isa_pkg::OP3_IN:   begin dec_d.src_in = 1'b1; dest_reg = 1'b1; end
				pat_isa_pkg::OP3_OUT:  dec_d.is_out = 1'b1;
				pat_isa_pkg::OP3_SETB: dec_d.is_setb = 1'b1;
				default: ;
			endcase
		end
		else
		begin
			case (op0)
				pat_isa_pkg::OP0_NOT:  begin dec_d.alu_op = pat_isa_pkg::ALU_NOT; dest_reg = 1'b1; end
				pat_isa_pkg::OP0_MOV:  begin dec_d.is_mov = 1'b1; dest_reg = 1'b1; end  // direction by field_op
				pat_isa_pkg::OP0_TEST: dec_d.is_test = 1'b1;
				default: ;                                           // nop
			endcase
		end
		dec_d.dest_acc = dest_reg && !fetch_q.field_op;
		dec_d.dest_field = dest_reg && fetch_q.field_op;
	end

	// memory data for the *m ops, i3 immediates are only 3 bits wide
	assign b_d = src_dmem ? i_dmem_rdata :
		is_i8 ? fetch_q.imm : {{(`PAT_D_WIDTH-3){1'b0}}, fetch_q.imm[2:0]};

	// ============================================================
	// fetch and decode registers
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fetch_q <= pat_isa_pkg::NOP_INSTR;
			dec_q <= '0;                        // decoded nop
		end
		else
		begin
			fetch_q <= i_instr;
			dec_q <= dec_d;
		end
		fetch_pc_q <= i_pc;
		b_q <= b_d;
		fval_q <= i_high_sel ? i_field_high : i_field_low;
	end

	assign o_fieldp = fetch_q.fieldp;          // field read in the decode cycle
	assign o_dmem_radr = fetch_q.imm[`PAT_DMEM_ADR_WIDTH-1:0];
	assign o_dec = dec_q;
	// lane 0 takes the accumulator at the top level
	assign o_lanes[0] = '{a: '0, b: b_q, op: dec_q.alu_op};
	assign o_lanes[1] = '{a: fval_q, b: b_q, op: dec_q.alu_op};

endmodule

`default_nettype wire

//--- logic/pat_isa_pkg.sv
`default_nettype none

`include "pat_cfg.svh"

package pat_isa_pkg;

	// i8 opcodes, top nibble of the low byte pair
	typedef enum logic [3:0] {
		OP8_OR   = 4'h0,
		OP8_AND  = 4'h1,
		OP8_ADDM = 4'h2,
		OP8_SUBM = 4'h3,
		OP8_ADD  = 4'h4,
		OP8_SUB  = 4'h5,
		OP8_LDI  = 4'h6,
		OP8_LDM  = 4'h7,
		OP8_BF   = 4'h8,  // relative forward branch
		OP8_STM  = 4'hB,
		OP8_ORM  = 4'hD,
		OP8_ANDM = 4'hE,
		OP8_ESC  = 4'hF   // escape into i3 space
	} op8_e;

	// i3 opcodes live in imm[7:4]
	typedef enum logic [3:0] {
		OP3_SHL  = 4'h0,
		OP3_SHLO = 4'h1,
		OP3_SHR  = 4'h2,
		OP3_ASR  = 4'h3,
		OP3_IN   = 4'h5,
		OP3_OUT  = 4'h8,
		OP3_SETB = 4'h9,
		OP3_ESC  = 4'hF   // escape into i0 space
	} op3_e;

	// i0 opcodes live in imm[3:0]
	typedef enum logic [3:0] {
		OP0_NOT  = 4'h0,
		OP0_MOV  = 4'h1,
		OP0_TEST = 4'h2,
		OP0_NOP  = 4'hF
	} op0_e;

	typedef enum logic [1:0] {
		COND_AL  = 2'd0,
		COND_Z   = 2'd1,
		COND_N   = 2'd2,
		COND_AL2 = 2'd3   // also always
	} cond_e;

	// lane function, shared by both lanes
	typedef enum logic [3:0] {
		ALU_PASS_B, ALU_OR, ALU_AND, ALU_NOT, ALU_ADD,
		ALU_SUB, ALU_SHL, ALU_SHLO, ALU_SHR, ALU_ASR
	} alu_op_e;

	typedef struct packed {
		logic [`PAT_FIELDP_WIDTH-1:0] fieldp;
		cond_e                        cond;
		logic                         field_op;  // 1: field path, 0: acc
		op8_e                         op8;
		logic [`PAT_D_WIDTH-1:0]      imm;
	} instr_t;

	// decode stage word handed to commit
	typedef struct packed {
		alu_op_e                      alu_op;
		cond_e                        cond;
		logic                         field_op;
		logic                         dest_acc;
		logic                         dest_field;
		logic                         dest_dmem;
		logic                         is_branch;
		logic                         is_test;
		logic                         is_out;
		logic                         is_setb;
		logic                         is_mov;
		logic                         src_in;
		logic [`PAT_D_WIDTH-1:0]      imm;      // raw, setb and stm need the full byte
		logic [`PAT_I_ADR_WIDTH-1:0]  addr;     // own address, branch base
		logic [`PAT_FIELDP_WIDTH-1:0] fieldp;
	} decoded_t;

	localparam instr_t NOP_INSTR = '{fieldp: '0, cond: COND_AL, field_op: 1'b0,
		op8: OP8_ESC, imm: 8'hFF};

endpackage

`default_nettype wire

//--- logic/pat_program_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "pat_cfg.svh"

module pat_program_counter (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_branch,
	input  logic [`PAT_I_ADR_WIDTH-1:0] i_target,
	output logic [`PAT_I_ADR_WIDTH-1:0] o_pc
);

	logic [`PAT_I_ADR_WIDTH-1:0] pc_q;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc_q <= '0;
		else if (i_branch)
			pc_q <= i_target;    // redirect from commit
		else
			pc_q <= pc_q + 1'b1;  // one fetch per cycle
	end

	assign o_pc = pc_q;

	// program memory address never goes unknown once running
	a_pc_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(pc_q));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build pat_tb with verilator and run it; pass only if the testbench reports it
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module pat_tb \
		-o pat_sim \
	&& ./obj_dir/pat_sim | tee /dev/stderr | grep -q "^NO ERRORS$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- sources.f
+incdir+logic
+incdir+bench
logic/pat_isa_pkg.sv
logic/pat_bus_pkg.sv
logic/pat_data_mem.sv
logic/pat_program_counter.sv
logic/pat_alu_lane.sv
logic/pat_decode.sv
logic/pat_commit.sv
logic/pat_core.sv
bench/pat_tb.sv
